/* logic/ddr_pkg.sv */
// Shared widths, command and state encodings, and the test data pattern for the DDR4 traffic test
`default_nettype none

package ddr_pkg;

  // ****************************************
  // Application port sizes
  // ****************************************
  localparam int unsigned APP_ADDR_WIDTH = 28;
  localparam int unsigned APP_DATA_WIDTH = 64;
  localparam int unsigned APP_MASK_WIDTH = 8;

  // Word and error counters
  localparam int unsigned COUNT_WIDTH = 16;
  localparam int unsigned SEED_WIDTH = 32;

  // One data word spans eight byte addresses
  localparam int unsigned ADDR_STEP = 8;

  // ****************************************
  // Encodings
  // ****************************************

  // Native port command codes
  typedef enum logic [2:0] {
    CMD_WRITE = 3'd0,
    CMD_READ  = 3'd1
  } app_cmd_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_WRITE,
    SEQ_READ,
    SEQ_DRAIN
  } seq_state_e;

  // ****************************************
  // Pattern
  // ****************************************

  // Upper half is seed XOR address, lower half its inverse
  function automatic logic [APP_DATA_WIDTH-1:0] pattern_word(
    input logic [APP_ADDR_WIDTH-1:0] addr,
    input logic [SEED_WIDTH-1:0]     seed
  );
    logic [SEED_WIDTH-1:0] upper;
    upper = seed ^ {{(SEED_WIDTH - APP_ADDR_WIDTH){1'b0}}, addr};
    return {upper, ~upper};
  endfunction

endpackage

`default_nettype wire

/* logic/ddr_test_if.sv */
// Latched test configuration, driven by the control block and read by the sequencer and checker
`default_nettype none

interface test_cfg_if;

  // Single-cycle launch strobe
  logic                               go;

  // Held stable from go until the next accepted start
  logic [ddr_pkg::APP_ADDR_WIDTH-1:0] base_addr;
  logic [ddr_pkg::COUNT_WIDTH-1:0]    word_count;
  logic [ddr_pkg::SEED_WIDTH-1:0]     seed;

  modport ctrl (
    output go, base_addr, word_count, seed
  );

  modport seq (
    input go, base_addr, word_count, seed
  );

  modport chk (
    input go, base_addr, word_count, seed
  );

endinterface

`default_nettype wire

/* logic/ddr_test_ctrl.sv */
// Test run control: qualifies the start pulse, latches the configuration and reports busy/done
`default_nettype none

module ddr_test_ctrl (
  input  wire                                c0_ddr4_clk,
  input  wire                                rst_i,
  input  wire                                init_calib_complete_i,
  input  wire                                start_i,
  input  wire [ddr_pkg::APP_ADDR_WIDTH-1:0]  base_addr_i,
  input  wire [ddr_pkg::COUNT_WIDTH-1:0]     word_count_i,
  input  wire [ddr_pkg::SEED_WIDTH-1:0]      seed_i,
  input  wire                                check_done_i,
  output logic                               test_busy_o,
  output logic                               test_done_o,
  test_cfg_if.ctrl                           cfg
);

  logic                               accept;
  logic                               go_q;
  logic                               busy_q;
  logic                               done_q;
  logic [ddr_pkg::APP_ADDR_WIDTH-1:0] base_q;
  logic [ddr_pkg::COUNT_WIDTH-1:0]    count_q;
  logic [ddr_pkg::SEED_WIDTH-1:0]     seed_q;

  // Start only after calibration, while idle, with a nonzero length
  assign accept = start_i && init_calib_complete_i && !busy_q &&
                  (word_count_i != '0);

  always_ff @(posedge c0_ddr4_clk) begin
    if (rst_i) begin
      go_q   <= 1'b0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      go_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (check_done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // Configuration snapshot
  always_ff @(posedge c0_ddr4_clk) begin
    if (accept) begin
      base_q  <= base_addr_i;
      count_q <= word_count_i;
      seed_q  <= seed_i;
    end
  end

  assign cfg.go         = go_q;
  assign cfg.base_addr  = base_q;
  assign cfg.word_count = count_q;
  assign cfg.seed       = seed_q;

  // Status flips in the same cycle as the checker's done pulse
  assign test_busy_o = busy_q && !check_done_i;
  assign test_done_o = done_q || check_done_i;

endmodule

`default_nettype wire

/* logic/ddr_app_sequencer.sv */
// Command sequencer for the DDR4 native port: writes the pattern over a range, then reads it back
`default_nettype none

module ddr_app_sequencer (
  input  wire                                 c0_ddr4_clk,
  input  wire                                 rst_i,
  test_cfg_if.seq                             cfg,
  input  wire                                 app_rdy_i,
  input  wire                                 app_wdf_rdy_i,
  output logic                                app_en_o,
  output ddr_pkg::app_cmd_e                   app_cmd_o,
  output logic [ddr_pkg::APP_ADDR_WIDTH-1:0]  app_addr_o,
  output logic [ddr_pkg::APP_DATA_WIDTH-1:0]  app_wdf_data_o,
  output logic [ddr_pkg::APP_MASK_WIDTH-1:0]  app_wdf_mask_o,
  output logic                                app_wdf_wren_o,
  output logic                                app_wdf_end_o
);

  ddr_pkg::seq_state_e                state_q;
  logic [ddr_pkg::COUNT_WIDTH-1:0]    cmd_cnt_q;
  logic [ddr_pkg::COUNT_WIDTH-1:0]    data_cnt_q;
  logic [ddr_pkg::APP_ADDR_WIDTH-1:0] cmd_addr_q;
  logic [ddr_pkg::APP_ADDR_WIDTH-1:0] data_addr_q;

  logic cmd_left;
  logic data_left;
  logic cmd_last;
  logic cmd_fire;
  logic data_fire;
  logic start_wr;
  logic start_rd;

  // ****************************************
  // Handshake qualifiers
  // ****************************************
  assign cmd_left  = cmd_cnt_q != cfg.word_count;
  assign data_left = data_cnt_q != cfg.word_count;
  assign cmd_last  = cmd_cnt_q == (cfg.word_count - 1'b1);

  assign cmd_fire  = app_en_o && app_rdy_i;
  assign data_fire = app_wdf_wren_o && app_wdf_rdy_i;

  assign start_wr = (state_q == ddr_pkg::SEQ_IDLE) && cfg.go;
  // Reads begin once every write-data word has gone out
  assign start_rd = (state_q == ddr_pkg::SEQ_DRAIN) && !data_left;

  // Strobes come straight from state, so they hold while ready is low
  always_comb begin
    app_en_o       = 1'b0;
    app_wdf_wren_o = 1'b0;
    app_cmd_o      = ddr_pkg::CMD_WRITE;
    unique case (state_q)
      ddr_pkg::SEQ_WRITE: begin
        app_en_o       = cmd_left;
        app_wdf_wren_o = data_left;
      end
      ddr_pkg::SEQ_DRAIN: begin
        app_wdf_wren_o = data_left;
      end
      ddr_pkg::SEQ_READ: begin
        app_en_o  = cmd_left;
        app_cmd_o = ddr_pkg::CMD_READ;
      end
      default: begin
        app_en_o = 1'b0;
      end
    endcase
  end

  assign app_addr_o     = cmd_addr_q;
  assign app_wdf_data_o = ddr_pkg::pattern_word(data_addr_q, cfg.seed);
  assign app_wdf_mask_o = '0;
  assign app_wdf_end_o  = app_wdf_wren_o;

  // ****************************************
  // Phase FSM and transfer counters
  // ****************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (rst_i) begin
      state_q    <= ddr_pkg::SEQ_IDLE;
      cmd_cnt_q  <= '0;
      data_cnt_q <= '0;
    end else begin
      unique case (state_q)
        ddr_pkg::SEQ_IDLE: begin
          if (start_wr) begin
            state_q    <= ddr_pkg::SEQ_WRITE;
            cmd_cnt_q  <= '0;
            data_cnt_q <= '0;
          end
        end
        ddr_pkg::SEQ_WRITE: begin
          // Commands and data advance independently
          if (cmd_fire) begin
            cmd_cnt_q <= cmd_cnt_q + 1'b1;
          end
          if (data_fire) begin
            data_cnt_q <= data_cnt_q + 1'b1;
          end
          if (cmd_fire && cmd_last) begin
            state_q <= ddr_pkg::SEQ_DRAIN;
          end
        end
        ddr_pkg::SEQ_DRAIN: begin
          if (data_fire) begin
            data_cnt_q <= data_cnt_q + 1'b1;
          end
          if (start_rd) begin
            state_q   <= ddr_pkg::SEQ_READ;
            cmd_cnt_q <= '0;
          end
        end
        ddr_pkg::SEQ_READ: begin
          if (cmd_fire) begin
            cmd_cnt_q <= cmd_cnt_q + 1'b1;
            if (cmd_last) begin
              state_q <= ddr_pkg::SEQ_IDLE;
            end
          end
        end
        default: begin
          state_q <= ddr_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  // Address pointers follow the same transfer events
  always_ff @(posedge c0_ddr4_clk) begin
    if (start_wr) begin
      cmd_addr_q  <= cfg.base_addr;
      data_addr_q <= cfg.base_addr;
    end else begin
      if (start_rd) begin
        cmd_addr_q <= cfg.base_addr;
      end else if (cmd_fire) begin
        cmd_addr_q <= cmd_addr_q + ddr_pkg::APP_ADDR_WIDTH'(ddr_pkg::ADDR_STEP);
      end
      if (data_fire) begin
        data_addr_q <= data_addr_q + ddr_pkg::APP_ADDR_WIDTH'(ddr_pkg::ADDR_STEP);
      end
    end
  end

endmodule

`default_nettype wire

/* logic/ddr_read_checker.sv */
// Read-back checker: compares returned words with the pattern and keeps the error results
`default_nettype none

module ddr_read_checker (
  input  wire                                 c0_ddr4_clk,
  input  wire                                 rst_i,
  test_cfg_if.chk                             cfg,
  input  wire [ddr_pkg::APP_DATA_WIDTH-1:0]   app_rd_data_i,
  input  wire                                 app_rd_data_valid_i,
  output logic                                check_done_o,
  output logic                                compare_error_o,
  output logic [ddr_pkg::COUNT_WIDTH-1:0]     error_count_o,
  output logic [ddr_pkg::APP_ADDR_WIDTH-1:0]  first_err_addr_o
);

  logic                               running_q;
  logic [ddr_pkg::COUNT_WIDTH-1:0]    rd_cnt_q;
  logic [ddr_pkg::APP_ADDR_WIDTH-1:0] exp_addr_q;
  logic [ddr_pkg::APP_DATA_WIDTH-1:0] exp_data;
  logic                               rd_take;
  logic                               rd_last;
  logic                               mismatch;

  // Expected word for the next returned read, in command order
  assign exp_data = ddr_pkg::pattern_word(exp_addr_q, cfg.seed);

  assign rd_take  = running_q && app_rd_data_valid_i;
  assign rd_last  = rd_cnt_q == (cfg.word_count - 1'b1);
  assign mismatch = rd_take && (app_rd_data_i != exp_data);

  // ****************************************
  // Progress and results
  // ****************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (rst_i) begin
      running_q        <= 1'b0;
      rd_cnt_q         <= '0;
      check_done_o     <= 1'b0;
      compare_error_o  <= 1'b0;
      error_count_o    <= '0;
      first_err_addr_o <= '0;
    end else begin
      check_done_o <= 1'b0;
      if (cfg.go) begin
        running_q        <= 1'b1;
        rd_cnt_q         <= '0;
        compare_error_o  <= 1'b0;
        error_count_o    <= '0;
        first_err_addr_o <= '0;
      end else begin
        if (rd_take) begin
          rd_cnt_q <= rd_cnt_q + 1'b1;
          if (rd_last) begin
            running_q    <= 1'b0;
            check_done_o <= 1'b1;
          end
        end
        if (mismatch) begin
          // Count saturates at all ones
          if (error_count_o != '1) begin
            error_count_o <= error_count_o + 1'b1;
          end
          if (!compare_error_o) begin
            compare_error_o  <= 1'b1;
            first_err_addr_o <= exp_addr_q;
          end
        end
      end
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (cfg.go) begin
      exp_addr_q <= cfg.base_addr;
    end else if (rd_take) begin
      exp_addr_q <= exp_addr_q + ddr_pkg::APP_ADDR_WIDTH'(ddr_pkg::ADDR_STEP);
    end
  end

endmodule

`default_nettype wire

/* logic/ddr_traffic_top.sv */
// Top level of the DDR4 traffic generator and checker, to be wired to the controller's native port
`default_nettype none

module ddr_traffic_top (
  input  wire                                 c0_ddr4_clk,
  input  wire                                 rst_i,
  input  wire                                 init_calib_complete_i,

  // Test control
  input  wire                                 start_i,
  input  wire [ddr_pkg::APP_ADDR_WIDTH-1:0]   base_addr_i,
  input  wire [ddr_pkg::COUNT_WIDTH-1:0]      word_count_i,
  input  wire [ddr_pkg::SEED_WIDTH-1:0]       seed_i,

  // Controller application port
  input  wire                                 app_rdy_i,
  input  wire                                 app_wdf_rdy_i,
  output logic                                app_en_o,
  output ddr_pkg::app_cmd_e                   app_cmd_o,
  output logic [ddr_pkg::APP_ADDR_WIDTH-1:0]  app_addr_o,
  output logic [ddr_pkg::APP_DATA_WIDTH-1:0]  app_wdf_data_o,
  output logic [ddr_pkg::APP_MASK_WIDTH-1:0]  app_wdf_mask_o,
  output logic                                app_wdf_wren_o,
  output logic                                app_wdf_end_o,
  input  wire [ddr_pkg::APP_DATA_WIDTH-1:0]   app_rd_data_i,
  input  wire                                 app_rd_data_valid_i,

  // Status and results
  output logic                                test_busy_o,
  output logic                                test_done_o,
  output logic                                compare_error_o,
  output logic [ddr_pkg::COUNT_WIDTH-1:0]     error_count_o,
  output logic [ddr_pkg::APP_ADDR_WIDTH-1:0]  first_err_addr_o
);

  logic check_done;

  test_cfg_if u_cfg_if ();

  // ****************************************
  // Control, sequencing and checking
  // ****************************************
  ddr_test_ctrl u_ddr_test_ctrl (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .rst_i                 (rst_i),
    .init_calib_complete_i (init_calib_complete_i),
    .start_i               (start_i),
    .base_addr_i           (base_addr_i),
    .word_count_i          (word_count_i),
    .seed_i                (seed_i),
    .check_done_i          (check_done),
    .test_busy_o           (test_busy_o),
    .test_done_o           (test_done_o),
    .cfg                   (u_cfg_if.ctrl)
  );

  ddr_app_sequencer u_ddr_app_sequencer (
    .c0_ddr4_clk    (c0_ddr4_clk),
    .rst_i          (rst_i),
    .cfg            (u_cfg_if.seq),
    .app_rdy_i      (app_rdy_i),
    .app_wdf_rdy_i  (app_wdf_rdy_i),
    .app_en_o       (app_en_o),
    .app_cmd_o      (app_cmd_o),
    .app_addr_o     (app_addr_o),
    .app_wdf_data_o (app_wdf_data_o),
    .app_wdf_mask_o (app_wdf_mask_o),
    .app_wdf_wren_o (app_wdf_wren_o),
    .app_wdf_end_o  (app_wdf_end_o)
  );

  ddr_read_checker u_ddr_read_checker (
    .c0_ddr4_clk         (c0_ddr4_clk),
    .rst_i               (rst_i),
    .cfg                 (u_cfg_if.chk),
    .app_rd_data_i       (app_rd_data_i),
    .app_rd_data_valid_i (app_rd_data_valid_i),
    .check_done_o        (check_done),
    .compare_error_o     (compare_error_o),
    .error_count_o       (error_count_o),
    .first_err_addr_o    (first_err_addr_o)
  );

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
// Testbench clock and reset source: 100 ns clock, reset held over the first three rising edges
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Synchronous reset spans three rising edges
  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* test/ddr_app_model.sv */
// Behavioral DDR4 native-port model: random ready, in-order delayed reads, single-address fault
`default_nettype none

module ddr_app_model (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire  [31:0] rnd_i,
  input  wire  [3:0]  drop_level_i,
  input  wire         fault_en_i,
  input  wire  [27:0] fault_addr_i,
  input  wire         app_en_i,
  input  wire  [2:0]  app_cmd_i,
  input  wire  [27:0] app_addr_i,
  input  wire  [63:0] app_wdf_data_i,
  input  wire         app_wdf_wren_i,
  output logic        app_rdy_o,
  output logic        app_wdf_rdy_o,
  output logic [63:0] app_rd_data_o,
  output logic        app_rd_data_valid_o,
  output logic        init_calib_complete_o,
  output logic [31:0] write_total_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned MEM_WORDS   = 1024;
  localparam int unsigned CALIB_DELAY = 8;

  logic [63:0] mem [MEM_WORDS];

  // Write commands and write data arrive independently
  logic [27:0] wr_addr_q [$];
  logic [63:0] wr_data_q [$];
  logic [27:0] rd_addr_q [$];
  int unsigned rd_due_q [$];

  int unsigned cycle;
  int unsigned last_due;
  int unsigned calib_cnt;
  logic        in_reset;

  function automatic logic [9:0] word_index(input logic [27:0] addr);
    return addr[12:3];
  endfunction

  // Power-up contents differ at every word address
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {32'ha5a5_0000 ^ 32'(i), ~32'(i)};
    end
    app_rdy_o             = 1'b0;
    app_wdf_rdy_o         = 1'b0;
    app_rd_data_o         = '0;
    app_rd_data_valid_o   = 1'b0;
    init_calib_complete_o = 1'b0;
    write_total_o         = '0;
    cycle                 = 0;
    last_due              = 0;
    calib_cnt             = 0;
    in_reset              = 1'b1;
  end

  always begin
    int unsigned latency;
    int unsigned due;
    logic [27:0] rd_addr;
    logic [63:0] rd_word;

    // ****************************************
    // Transfers, sampled mid-cycle
    // ****************************************
    @(negedge clk_i);
    in_reset = rst_i;
    if (in_reset) begin
      wr_addr_q.delete();
      wr_data_q.delete();
      rd_addr_q.delete();
      rd_due_q.delete();
      last_due = 0;
    end else begin
      if (app_en_i && app_rdy_o) begin
        if (app_cmd_i == ddr_pkg::CMD_READ) begin
          latency = 2 + (rnd_i[10:8] % 5);
          due     = cycle + latency;
          // Keep returns in command order
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          rd_addr_q.push_back(app_addr_i);
          rd_due_q.push_back(due);
        end else begin
          wr_addr_q.push_back(app_addr_i);
        end
      end
      if (app_wdf_wren_i && app_wdf_rdy_o) begin
        wr_data_q.push_back(app_wdf_data_i);
      end
      while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
        mem[word_index(wr_addr_q.pop_front())] = wr_data_q.pop_front();
        write_total_o = write_total_o + 1;
      end
    end

    // ****************************************
    // Outputs, driven just after the edge
    // ****************************************
    @(posedge clk_i);
    #1;
    cycle = cycle + 1;
    if (in_reset) begin
      calib_cnt             = 0;
      init_calib_complete_o = 1'b0;
      app_rdy_o             = 1'b0;
      app_wdf_rdy_o         = 1'b0;
      app_rd_data_valid_o   = 1'b0;
    end else begin
      if (calib_cnt < CALIB_DELAY) begin
        calib_cnt = calib_cnt + 1;
      end else begin
        init_calib_complete_o = 1'b1;
      end
      app_rdy_o     = init_calib_complete_o && (rnd_i[3:0] >= drop_level_i);
      app_wdf_rdy_o = init_calib_complete_o && (rnd_i[7:4] >= drop_level_i);
      if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
        due     = rd_due_q.pop_front();
        rd_addr = rd_addr_q.pop_front();
        rd_word = mem[word_index(rd_addr)];
        if (fault_en_i && rd_addr == fault_addr_i) begin
          rd_word[0] = ~rd_word[0];
        end
        app_rd_data_o       = rd_word;
        app_rd_data_valid_o = 1'b1;
      end else begin
        app_rd_data_valid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* test/tb_ddr_traffic_top.sv */
// Testbench top for the DDR4 traffic generator: table-driven runs against the native-port model
`default_nettype none

module tb_ddr_traffic_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NUM_TESTS       = 6;
  localparam int unsigned CYCLES_PER_WORD = 40;
  localparam int unsigned TIMEOUT_MARGIN  = 1000;
  localparam int unsigned IDLE_WINDOW     = 40;
  localparam logic [31:0] RND_SEED        = 32'h46fc_babb;

  typedef struct {
    logic [27:0] base;
    logic [15:0] count;
    logic [31:0] seed;
    logic        fault_en;
    logic [27:0] fault_addr;
    logic        accept;
    logic        restart;
    logic [3:0]  drop_level;
  } test_row_t;

  logic clk;
  logic rst;
  logic calib;
  logic start;
  logic [27:0] base_addr;
  logic [15:0] word_count;
  logic [31:0] seed_in;
  logic app_rdy;
  logic app_wdf_rdy;
  logic app_en;
  ddr_pkg::app_cmd_e app_cmd;
  logic [27:0] app_addr;
  logic [63:0] app_wdf_data;
  logic [7:0] app_wdf_mask;
  logic app_wdf_wren;
  logic app_wdf_end;
  logic [63:0] app_rd_data;
  logic app_rd_data_valid;
  logic test_busy;
  logic test_done;
  logic compare_error;
  logic [15:0] error_count;
  logic [27:0] first_err_addr;

  logic fault_en;
  logic [27:0] fault_addr;
  logic [3:0] drop_level;
  logic [31:0] write_total;
  logic [31:0] rnd_q = RND_SEED;

  test_row_t tests [NUM_TESTS];
  int unsigned check_errors = 0;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  ddr_traffic_top u_ddr_traffic_top (
    .c0_ddr4_clk           (clk),
    .rst_i                 (rst),
    .init_calib_complete_i (calib),
    .start_i               (start),
    .base_addr_i           (base_addr),
    .word_count_i          (word_count),
    .seed_i                (seed_in),
    .app_rdy_i             (app_rdy),
    .app_wdf_rdy_i         (app_wdf_rdy),
    .app_en_o              (app_en),
    .app_cmd_o             (app_cmd),
    .app_addr_o            (app_addr),
    .app_wdf_data_o        (app_wdf_data),
    .app_wdf_mask_o        (app_wdf_mask),
    .app_wdf_wren_o        (app_wdf_wren),
    .app_wdf_end_o         (app_wdf_end),
    .app_rd_data_i         (app_rd_data),
    .app_rd_data_valid_i   (app_rd_data_valid),
    .test_busy_o           (test_busy),
    .test_done_o           (test_done),
    .compare_error_o       (compare_error),
    .error_count_o         (error_count),
    .first_err_addr_o      (first_err_addr)
  );

  ddr_app_model u_app_model (
    .clk_i                 (clk),
    .rst_i                 (rst),
    .rnd_i                 (rnd_q),
    .drop_level_i          (drop_level),
    .fault_en_i            (fault_en),
    .fault_addr_i          (fault_addr),
    .app_en_i              (app_en),
    .app_cmd_i             (app_cmd),
    .app_addr_i            (app_addr),
    .app_wdf_data_i        (app_wdf_data),
    .app_wdf_wren_i        (app_wdf_wren),
    .app_rdy_o             (app_rdy),
    .app_wdf_rdy_o         (app_wdf_rdy),
    .app_rd_data_o         (app_rd_data),
    .app_rd_data_valid_o   (app_rd_data_valid),
    .init_calib_complete_o (calib),
    .write_total_o         (write_total)
  );

  // ****************************************
  // Helpers
  // ****************************************
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Upper half is seed XOR address, lower half its inverse
  function automatic logic [63:0] expected_word(input logic [27:0] addr, input logic [31:0] seed);
    logic [31:0] upper;
    upper = seed ^ {4'b0000, addr};
    return {upper, ~upper};
  endfunction

  function automatic logic fault_in_range(input test_row_t row);
    logic [31:0] offset;
    if (!row.fault_en || row.fault_addr < row.base) begin
      return 1'b0;
    end
    offset = {4'b0000, row.fault_addr - row.base};
    return (offset[2:0] == 3'b000) && (offset < {13'b0, row.count, 3'b000});
  endfunction

  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      check_errors++;
    end
  endtask

  task automatic drive_start(input logic [27:0] base, input logic [15:0] count,
                             input logic [31:0] seed);
    @(posedge clk);
    #1;
    start      = 1'b1;
    base_addr  = base;
    word_count = count;
    seed_in    = seed;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic wait_done();
    @(negedge clk);
    while (!test_done) begin
      @(negedge clk);
    end
  endtask

  // Read the model memory directly, so dropped or doubled writes show up
  task automatic verify_memory(input test_row_t row);
    logic [27:0] addr;
    for (int i = 0; i < int'(row.count); i++) begin
      addr = row.base + 28'(i * 8);
      check_value("memory word", u_app_model.mem[addr[12:3]], expected_word(addr, row.seed));
    end
  endtask

  always @(posedge clk) begin
    rnd_q <= xorshift32(rnd_q);
  end

  // Single-word bursts with every byte enabled
  always @(negedge clk) begin
    if (!rst) begin
      if (app_wdf_wren) begin
        check_value("app_wdf_end", 64'(app_wdf_end), 64'd1);
        check_value("app_wdf_mask", 64'(app_wdf_mask), 64'd0);
      end else begin
        check_value("app_wdf_end", 64'(app_wdf_end), 64'd0);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ****************************************
  // Stimulus table and test loop
  // ****************************************
  initial begin
    test_row_t   row;
    int unsigned total_words;
    int unsigned errors_before;
    int unsigned passed;
    logic [31:0] writes_before;
    logic        exp_done;
    logic        exp_cmp;
    logic [15:0] exp_count;
    logic [27:0] exp_first;

    start      = 1'b0;
    base_addr  = '0;
    word_count = '0;
    seed_in    = '0;
    fault_en   = 1'b0;
    fault_addr = '0;
    drop_level = 4'd0;

    // base, count, seed, fault_en, fault_addr, accept, restart, drop_level
    tests[0] = '{28'h0000, 16'd16, 32'h1357_9bdf, 1'b0, 28'h0000, 1'b1, 1'b0, 4'd3};
    tests[1] = '{28'h0200, 16'd16, 32'h2468_ace0, 1'b1, 28'h0240, 1'b1, 1'b0, 4'd3};
    tests[2] = '{28'h0400, 16'd8,  32'h0f0f_5a5a, 1'b1, 28'h0500, 1'b1, 1'b0, 4'd3};
    tests[3] = '{28'h0800, 16'd64, 32'hc3c3_0101, 1'b0, 28'h0000, 1'b1, 1'b0, 4'd12};
    tests[4] = '{28'h1000, 16'd32, 32'h7e57_1234, 1'b1, 28'h1008, 1'b1, 1'b1, 4'd3};
    tests[5] = '{28'h0c00, 16'd0,  32'hffff_0000, 1'b0, 28'h0000, 1'b0, 1'b0, 4'd3};

    total_words = 0;
    foreach (tests[i]) begin
      total_words += 32'(tests[i].count);
    end
    cycle_limit = total_words * CYCLES_PER_WORD + TIMEOUT_MARGIN;

    @(negedge clk);
    while (rst || !calib) begin
      @(negedge clk);
    end

    exp_done  = 1'b0;
    exp_cmp   = 1'b0;
    exp_count = '0;
    exp_first = '0;
    passed    = 0;

    for (int t = 0; t < NUM_TESTS; t++) begin
      row           = tests[t];
      errors_before = check_errors;
      writes_before = write_total;
      fault_en      = row.fault_en;
      fault_addr    = row.fault_addr;
      drop_level    = row.drop_level;

      drive_start(row.base, row.count, row.seed);
      // A second start in the middle of the run must be ignored
      if (row.restart) begin
        repeat (4) @(negedge clk);
        check_value("busy before second start", 64'(test_busy), 64'd1);
        drive_start(28'h0000, 16'd4, 32'h0bad_0bad);
      end

      if (row.accept) begin
        wait_done();
        exp_done  = 1'b1;
        exp_cmp   = fault_in_range(row);
        exp_count = exp_cmp ? 16'd1 : 16'd0;
        exp_first = exp_cmp ? row.fault_addr : 28'h0;
        verify_memory(row);
        check_value("words written", 64'(write_total - writes_before), 64'(row.count));
      end else begin
        repeat (IDLE_WINDOW) @(negedge clk);
        check_value("words written", 64'(write_total - writes_before), 64'd0);
      end

      check_value("test_done", 64'(test_done), 64'(exp_done));
      check_value("test_busy", 64'(test_busy), 64'd0);
      check_value("compare_error", 64'(compare_error), 64'(exp_cmp));
      check_value("error_count", 64'(error_count), 64'(exp_count));
      check_value("first_err_addr", 64'(first_err_addr), 64'(exp_first));

      if (check_errors == errors_before) begin
        passed++;
        $display("Test %0d: base %0h, %0d words: passed", t, row.base, row.count);
      end else begin
        $display("Test %0d: base %0h, %0d words: failed with %0d mismatches", t, row.base,
                 row.count, check_errors - errors_before);
      end
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d", NUM_TESTS, passed, NUM_TESTS - passed);
    if (check_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
logic/ddr_pkg.sv
logic/ddr_test_if.sv
logic/ddr_test_ctrl.sv
logic/ddr_app_sequencer.sv
logic/ddr_read_checker.sv
logic/ddr_traffic_top.sv
test/tb_clk_gen.sv
test/ddr_app_model.sv
test/tb_ddr_traffic_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DDR4 traffic testbench with Verilator; exit status follows the result
rm -f sim.log
verilator --binary --timing -f project.f --top-module tb_ddr_traffic_top -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  || { echo "Build or simulation run failed"; exit 1; }
grep -q "^Simulation finished: PASS$" sim.log && echo "Log shows a passing run" || exit 1
